// File: run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

log=sim.log
rm -rf obj_dir

verilator --binary --timing --assert -j 0 \
    -f udp_rx_noc_out.f \
    --top-module udp_rx_noc_out_tb \
    -o udp_rx_noc_out_sim

# The simulator exits non-zero on $fatal, and the log is searched below.
./obj_dir/udp_rx_noc_out_sim 2>&1 | tee "$log" || true

if grep -q "FAIL: see errors above" "$log"; then
    echo "Simulation failed."
    exit 1
fi
echo "Simulation passed."

// File: source/port_table.sv
module port_table #(
     parameter int table_entries = 8
)(
     input  logic                              clk
    ,input  logic                              rst

    ,input  logic                              cfg_valid
    ,input  logic [$clog2(table_entries)-1:0]  cfg_index
    ,input  udp_rx_pkg::port_entry             cfg_entry

    ,input  logic [15:0]                       lookup_port
    ,output logic                              hit
    ,output udp_rx_pkg::noc_dest               dest
);

    udp_rx_pkg::port_entry slots [table_entries];

    // Software writes a slot by index; a write is visible on the next cycle.
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < table_entries; i++) begin
                slots[i] <= '0;
            end
        end
        else if (cfg_valid) begin
            slots[cfg_index] <= cfg_entry;
        end
    end

    // Every valid slot is compared at once.
    // The first match in index order wins, so duplicates resolve to the lowest slot.
    always_comb begin
        hit  = 1'b0;
        dest = '0;
        for (int i = 0; i < table_entries; i++) begin
            if (!hit && slots[i].valid && (slots[i].port == lookup_port)) begin
                hit  = 1'b1;
                dest = slots[i].dest;
            end
        end
    end

    // Software must stay inside the table.
    cfg_index_in_range: assert property (
        @(posedge clk) disable iff (rst)
        cfg_valid |-> (int'(cfg_index) < table_entries)
    ) else $error("port_table: cfg_index %0d out of range", cfg_index);

endmodule

// File: source/udp_rx_noc_out.sv
module udp_rx_noc_out #(
     parameter int src_x         = 1
    ,parameter int src_y         = 2
    ,parameter int table_entries = 8
)(
     input  logic                                  clk
    ,input  logic                                  rst

    ,input  logic                                  hdr_valid
    ,input  logic [udp_rx_pkg::ip_w-1:0]           src_ip
    ,input  logic [udp_rx_pkg::ip_w-1:0]           dst_ip
    ,input  udp_rx_pkg::udp_pkt_hdr                udp_hdr
    ,input  udp_rx_pkg::pkt_stamp                  stamp

    ,input  logic                                  beat_valid
    ,input  logic [udp_rx_pkg::data_w-1:0]         beat_data
    ,input  logic                                  beat_last
    ,input  logic [udp_rx_pkg::data_bytes_w-1:0]   beat_padbytes

    ,input  logic                                  cfg_valid
    ,input  logic [$clog2(table_entries)-1:0]      cfg_index
    ,input  udp_rx_pkg::port_entry                 cfg_entry

    ,output logic                                  flit_valid
    ,output logic [udp_rx_pkg::data_w-1:0]         flit
    ,output logic [15:0]                           drop_count
);

    logic                 hit;
    udp_rx_pkg::noc_dest  dest;
    logic [15:0]          lookup_port;
    logic                 store;
    udp_rx_pkg::flit_sel  sel;
    logic                 dly_valid;
    logic                 dly_last;
    logic                 no_data;

    port_table #(
         .table_entries (table_entries)
    ) port_table_inst (
         .clk           (clk)
        ,.rst           (rst)
        ,.cfg_valid     (cfg_valid)
        ,.cfg_index     (cfg_index)
        ,.cfg_entry     (cfg_entry)
        ,.lookup_port   (lookup_port)
        ,.hit           (hit)
        ,.dest          (dest)
    );

    udp_rx_noc_out_ctrl ctrl_inst (
         .clk           (clk)
        ,.rst           (rst)
        ,.hdr_valid     (hdr_valid)
        ,.hit           (hit)
        ,.no_data       (no_data)
        ,.dly_valid     (dly_valid)
        ,.dly_last      (dly_last)
        ,.store         (store)
        ,.sel           (sel)
        ,.flit_valid    (flit_valid)
        ,.drop_count    (drop_count)
    );

    udp_rx_noc_out_datap #(
         .src_x         (src_x)
        ,.src_y         (src_y)
    ) datap_inst (
         .clk           (clk)
        ,.rst           (rst)
        ,.src_ip        (src_ip)
        ,.dst_ip        (dst_ip)
        ,.udp_hdr       (udp_hdr)
        ,.stamp         (stamp)
        ,.beat_valid    (beat_valid)
        ,.beat_data     (beat_data)
        ,.beat_last     (beat_last)
        ,.beat_padbytes (beat_padbytes)
        ,.store         (store)
        ,.sel           (sel)
        ,.lookup_port   (lookup_port)
        ,.dest          (dest)
        ,.flit          (flit)
        ,.dly_valid     (dly_valid)
        ,.dly_last      (dly_last)
        ,.no_data       (no_data)
    );

endmodule

// File: source/udp_rx_noc_out_ctrl.sv
module udp_rx_noc_out_ctrl (
     input  logic                 clk
    ,input  logic                 rst

    ,input  logic                 hdr_valid
    ,input  logic                 hit
    ,input  logic                 no_data
    ,input  logic                 dly_valid
    ,input  logic                 dly_last

    ,output logic                 store
    ,output udp_rx_pkg::flit_sel  sel
    ,output logic                 flit_valid
    ,output logic [15:0]          drop_count
);

    udp_rx_pkg::ctrl_state state;
    udp_rx_pkg::ctrl_state state_next;

    assign store = hdr_valid && (state == udp_rx_pkg::st_idle);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= udp_rx_pkg::st_idle;
        end
        else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            udp_rx_pkg::st_idle: begin
                if (hdr_valid) begin
                    state_next = hit ? udp_rx_pkg::st_hdr : udp_rx_pkg::st_drop;
                end
            end
            udp_rx_pkg::st_hdr: begin
                state_next = udp_rx_pkg::st_meta;
            end
            udp_rx_pkg::st_meta: begin
                state_next = no_data ? udp_rx_pkg::st_idle : udp_rx_pkg::st_data;
            end
            udp_rx_pkg::st_data: begin
                if (dly_valid && dly_last) begin
                    state_next = udp_rx_pkg::st_idle;
                end
            end
            udp_rx_pkg::st_drop: begin
                // Beats of a dropped datagram still pass the delay line and are ignored.
                if (no_data || (dly_valid && dly_last)) begin
                    state_next = udp_rx_pkg::st_idle;
                end
            end
            default: begin
                state_next = udp_rx_pkg::st_idle;
            end
        endcase
    end

    always_comb begin
        case (state)
            udp_rx_pkg::st_hdr:  sel = udp_rx_pkg::sel_hdr;
            udp_rx_pkg::st_meta: sel = udp_rx_pkg::sel_meta;
            default:             sel = udp_rx_pkg::sel_data;
        endcase
    end

    assign flit_valid = (state == udp_rx_pkg::st_hdr)
                     || (state == udp_rx_pkg::st_meta)
                     || ((state == udp_rx_pkg::st_data) && dly_valid);

    always_ff @(posedge clk) begin
        if (rst) begin
            drop_count <= '0;
        end
        else if (store && !hit) begin
            drop_count <= drop_count + 16'd1; // Counted as the miss is seen.
        end
    end

    // The formatter spaces datagrams so a header never lands mid-message.
    hdr_only_in_idle: assert property (
        @(posedge clk) disable iff (rst)
        hdr_valid |-> (state == udp_rx_pkg::st_idle)
    ) else $error("udp_rx_noc_out_ctrl: header strobe outside idle");

    // Beats are two cycles late, so none can reach control before the metadata flit.
    no_beat_before_meta: assert property (
        @(posedge clk) disable iff (rst)
        dly_valid |-> !(state inside {udp_rx_pkg::st_idle, udp_rx_pkg::st_hdr})
    ) else $error("udp_rx_noc_out_ctrl: delayed beat in state %s", state.name());

endmodule

// File: source/udp_rx_noc_out_datap.sv
module udp_rx_noc_out_datap #(
     parameter int src_x = 0
    ,parameter int src_y = 0
)(
     input  logic                                  clk
    ,input  logic                                  rst

    ,input  logic [udp_rx_pkg::ip_w-1:0]           src_ip
    ,input  logic [udp_rx_pkg::ip_w-1:0]           dst_ip
    ,input  udp_rx_pkg::udp_pkt_hdr                udp_hdr
    ,input  udp_rx_pkg::pkt_stamp                  stamp

    ,input  logic                                  beat_valid
    ,input  logic [udp_rx_pkg::data_w-1:0]         beat_data
    ,input  logic                                  beat_last
    ,input  logic [udp_rx_pkg::data_bytes_w-1:0]   beat_padbytes

    ,input  logic                                  store
    ,input  udp_rx_pkg::flit_sel                   sel

    ,output logic [15:0]                           lookup_port
    ,input  udp_rx_pkg::noc_dest                   dest

    ,output logic [udp_rx_pkg::data_w-1:0]         flit
    ,output logic                                  dly_valid
    ,output logic                                  dly_last
    ,output logic                                  no_data
);

    localparam logic [udp_rx_pkg::fbits_w-1:0] src_fbits = 4'h1; // Packet interface endpoint.
    localparam int beat_bytes = udp_rx_pkg::data_w / 8;

    logic [udp_rx_pkg::ip_w-1:0] src_ip_q;
    logic [udp_rx_pkg::ip_w-1:0] dst_ip_q;
    udp_rx_pkg::udp_pkt_hdr      udp_hdr_q;
    udp_rx_pkg::pkt_stamp        stamp_q;
    udp_rx_pkg::noc_dest         dest_q;

    logic [15:0] payload_len;
    logic [16:0] payload_round;
    logic [7:0]  msg_len;

    udp_rx_pkg::noc_hdr_flit  hdr_flit;
    udp_rx_pkg::udp_meta_flit meta_flit;

    logic                                valid_s1;
    logic                                last_s1;
    logic [udp_rx_pkg::data_w-1:0]       data_s1;
    logic [udp_rx_pkg::data_bytes_w-1:0] pad_s1;
    logic                                valid_s2;
    logic                                last_s2;
    logic [udp_rx_pkg::data_w-1:0]       data_s2;
    logic [udp_rx_pkg::data_bytes_w-1:0] pad_s2;
    logic [udp_rx_pkg::data_w-1:0]       masked_data;

    // The table sees the arriving header in the same cycle as the strobe.
    assign lookup_port = udp_hdr.dst_port;

    always_ff @(posedge clk) begin
        if (store) begin
            src_ip_q  <= src_ip;
            dst_ip_q  <= dst_ip;
            udp_hdr_q <= udp_hdr;
            stamp_q   <= stamp;
            dest_q    <= dest; // Keeps the route even if the slot is rewritten later.
        end
    end

    assign payload_len   = udp_hdr_q.length - udp_rx_pkg::udp_hdr_bytes;
    assign payload_round = {1'b0, payload_len} + 17'd15;
    assign msg_len       = payload_round[udp_rx_pkg::data_bytes_w +: 8] + 8'd1;
    assign no_data       = (udp_hdr_q.length == udp_rx_pkg::udp_hdr_bytes);

    always_comb begin
        hdr_flit                = '0;
        hdr_flit.dst            = dest_q;
        hdr_flit.src_x          = src_x[udp_rx_pkg::xy_w-1:0];
        hdr_flit.src_y          = src_y[udp_rx_pkg::xy_w-1:0];
        hdr_flit.src_fbits      = src_fbits;
        hdr_flit.msg_len        = msg_len; // One metadata flit plus the data flits.
        hdr_flit.msg_type       = udp_rx_pkg::msg_type_udp_rx;
        hdr_flit.packet_id      = stamp_q.packet_id;
        hdr_flit.timestamp      = stamp_q.timestamp;
        hdr_flit.metadata_flits = 4'd1;
    end

    always_comb begin
        meta_flit             = '0;
        meta_flit.src_ip      = src_ip_q;
        meta_flit.dst_ip      = dst_ip_q;
        meta_flit.src_port    = udp_hdr_q.src_port;
        meta_flit.dst_port    = udp_hdr_q.dst_port;
        meta_flit.data_length = payload_len;
        meta_flit.timestamp   = stamp_q.timestamp;
    end

    // Two-stage delay line that holds the beats back behind the header and metadata flits.
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_s1 <= 1'b0;
            valid_s2 <= 1'b0;
        end
        else begin
            valid_s1 <= beat_valid;
            valid_s2 <= valid_s1;
        end
    end

    always_ff @(posedge clk) begin
        last_s1 <= beat_last;
        data_s1 <= beat_data;
        pad_s1  <= beat_padbytes;
        last_s2 <= last_s1;
        data_s2 <= data_s1;
        pad_s2  <= pad_s1;
    end

    assign dly_valid = valid_s2;
    assign dly_last  = valid_s2 && last_s2;

    // Pad bytes sit at the top of the last beat.
    always_comb begin
        masked_data = data_s2;
        if (last_s2) begin
            for (int i = 0; i < beat_bytes; i++) begin
                if (i >= beat_bytes - int'(pad_s2)) begin
                    masked_data[8*i +: 8] = 8'h00;
                end
            end
        end
    end

    always_comb begin
        case (sel)
            udp_rx_pkg::sel_hdr:  flit = hdr_flit;
            udp_rx_pkg::sel_meta: flit = meta_flit;
            default:              flit = masked_data;
        endcase
    end

endmodule

// File: source/udp_rx_pkg.sv
package udp_rx_pkg;

    localparam int data_w       = 128;
    localparam int data_bytes_w = 4;   // log2 of the bytes in one beat.
    localparam int xy_w         = 4;
    localparam int fbits_w      = 4;
    localparam int ip_w         = 32;

    // The UDP length field counts its own 8-byte header.
    localparam logic [15:0] udp_hdr_bytes   = 16'd8;
    localparam logic [7:0]  msg_type_udp_rx = 8'h0c;

    typedef struct packed {
        logic [15:0] src_port;
        logic [15:0] dst_port;
        logic [15:0] length;
        logic [15:0] checksum;
    } udp_pkt_hdr;

    typedef struct packed {
        logic [15:0] packet_id;
        logic [15:0] timestamp;
    } pkt_stamp;

    typedef struct packed {
        logic [xy_w-1:0]    x_coord;
        logic [xy_w-1:0]    y_coord;
        logic [fbits_w-1:0] fbits;
    } noc_dest;

    // One slot of the port table.
    typedef struct packed {
        logic        valid;
        logic [15:0] port;
        noc_dest     dest;
    } port_entry;

    typedef struct packed {
        noc_dest            dst;
        logic [xy_w-1:0]    src_x;
        logic [xy_w-1:0]    src_y;
        logic [fbits_w-1:0] src_fbits;
        logic [7:0]         msg_len;        // Flits after the header.
        logic [7:0]         msg_type;
        logic [15:0]        packet_id;
        logic [15:0]        timestamp;
        logic [3:0]         metadata_flits;
        logic [51:0]        padding;
    } noc_hdr_flit;

    typedef struct packed {
        logic [ip_w-1:0] src_ip;
        logic [ip_w-1:0] dst_ip;
        logic [15:0]     src_port;
        logic [15:0]     dst_port;
        logic [15:0]     data_length;
        logic [15:0]     timestamp;
    } udp_meta_flit;

    typedef enum logic [2:0] {st_idle, st_hdr, st_meta, st_data, st_drop} ctrl_state;

    typedef enum logic [1:0] {sel_hdr, sel_meta, sel_data} flit_sel;

endpackage

// File: tests/udp_rx_noc_out_tb.sv
module udp_rx_noc_out_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int src_x         = 1;
    localparam int src_y         = 2;
    localparam int table_entries = 8;
    localparam int idx_w         = $clog2(table_entries);
    localparam int n_dgrams      = 32;
    localparam logic [3:0] tile_fbits = 4'h1; // Endpoint of the packet interface.

    logic                   clk = 1'b0;
    logic                   rst;
    logic                   hdr_valid;
    logic [31:0]            src_ip;
    logic [31:0]            dst_ip;
    udp_rx_pkg::udp_pkt_hdr udp_hdr;
    udp_rx_pkg::pkt_stamp   stamp;
    logic                   beat_valid;
    logic [127:0]           beat_data;
    logic                   beat_last;
    logic [3:0]             beat_padbytes;
    logic                   cfg_valid;
    logic [idx_w-1:0]       cfg_index;
    udp_rx_pkg::port_entry  cfg_entry;
    logic                   flit_valid;
    logic [127:0]           flit;
    logic [15:0]            drop_count;

    logic [31:0]           lcg_state = 32'd26;
    udp_rx_pkg::port_entry mirror [table_entries];
    logic [127:0]          exp_flits [$];
    string                 exp_names [$];
    int                    payload_len [n_dgrams];
    int                    gap_len [n_dgrams];
    int                    cycle_limit = 0;
    int                    cycle_count = 0;
    int                    next_check = 0;
    int                    exp_drops = 0;

    udp_rx_noc_out #(
         .src_x         (src_x)
        ,.src_y         (src_y)
        ,.table_entries (table_entries)
    ) udp_rx_noc_out_inst (.*);

    always #4 clk = ~clk;

    function automatic logic [31:0] rand32();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic int rand_below(int n);
        logic [31:0] r;
        r = rand32();
        return int'(r[31:16]) % n; // The upper half has the longer period.
    endfunction

    task automatic abort_run();
        $display("FAIL: see errors above");
        $fatal(1, "udp_rx_noc_out_tb stopped at the first error");
    endtask

    task automatic report_mismatch(string name, logic [127:0] exp, logic [127:0] act);
        $display("FAILED %s: expected %h, actual %h", name, exp, act);
        abort_run();
    endtask

    task automatic idle_cycles(int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    // Lowest valid slot with the port, or -1 on a miss.
    function automatic int mirror_lookup(logic [15:0] port);
        for (int i = 0; i < table_entries; i++) begin
            if (mirror[i].valid && mirror[i].port == port) return i;
        end
        return -1;
    endfunction

    function automatic udp_rx_pkg::port_entry random_entry(logic [15:0] port, logic valid);
        udp_rx_pkg::port_entry e;
        e.valid = valid;
        e.port  = port;
        e.dest  = 12'(rand32() >> 8);
        return e;
    endfunction

    function automatic logic [127:0] expected_hdr(udp_rx_pkg::noc_dest d, int payload,
                                                  udp_rx_pkg::pkt_stamp s);
        udp_rx_pkg::noc_hdr_flit h;
        h                = '0;
        h.dst            = d;
        h.src_x          = 4'(src_x);
        h.src_y          = 4'(src_y);
        h.src_fbits      = tile_fbits;
        h.msg_len        = 8'(1 + (payload + 15) / 16); // Metadata plus whole data flits.
        h.msg_type       = udp_rx_pkg::msg_type_udp_rx;
        h.packet_id      = s.packet_id;
        h.timestamp      = s.timestamp;
        h.metadata_flits = 4'd1;
        return h;
    endfunction

    task automatic draw_lengths();
        int beats;
        cycle_limit = 2 * table_entries + 20; // Reset and table fill.
        for (int i = 0; i < n_dgrams; i++) begin
            payload_len[i] = (i % 8 == 3) ? 0 : rand_below(73);
            gap_len[i]     = 3 + rand_below(4);
            beats          = (payload_len[i] + 15) / 16;
            cycle_limit   += 2 * (1 + beats + gap_len[i]);
        end
    endtask

    task automatic write_slot(int idx, udp_rx_pkg::port_entry e);
        cfg_valid   = 1'b1;
        cfg_index   = idx_w'(idx);
        cfg_entry   = e;
        mirror[idx] = e;
        idle_cycles(1);
        cfg_valid   = 1'b0;
    endtask

    task automatic send_datagram(int i, logic [15:0] port);
        int                       nbeats;
        int                       pad;
        int                       slot;
        logic [127:0]             data;
        udp_rx_pkg::udp_pkt_hdr   h;
        udp_rx_pkg::pkt_stamp     s;
        udp_rx_pkg::udp_meta_flit m;
        nbeats     = (payload_len[i] + 15) / 16;
        pad        = nbeats * 16 - payload_len[i];
        h.src_port = 16'(rand32());
        h.dst_port = port;
        h.length   = 16'(payload_len[i] + 8);
        h.checksum = 16'(rand32());
        s          = rand32();
        hdr_valid  = 1'b1;
        src_ip     = rand32();
        dst_ip     = rand32();
        udp_hdr    = h;
        stamp      = s;
        slot       = mirror_lookup(port);
        if (slot < 0) begin
            exp_drops++;
        end
        else begin
            m               = '0;
            m.src_ip        = src_ip;
            m.dst_ip        = dst_ip;
            m.src_port      = h.src_port;
            m.dst_port      = h.dst_port;
            m.data_length   = 16'(payload_len[i]);
            m.timestamp     = s.timestamp;
            exp_flits.push_back(expected_hdr(mirror[slot].dest, payload_len[i], s));
            exp_names.push_back($sformatf("datagram %0d header flit", i));
            exp_flits.push_back(m);
            exp_names.push_back($sformatf("datagram %0d metadata flit", i));
        end
        idle_cycles(1);
        hdr_valid = 1'b0;
        for (int b = 0; b < nbeats; b++) begin
            data          = {rand32(), rand32(), rand32(), rand32()};
            beat_valid    = 1'b1;
            beat_data     = data; // Pad bytes go out as garbage.
            beat_last     = (b == nbeats - 1);
            beat_padbytes = beat_last ? 4'(pad) : 4'd0;
            if (beat_last) begin
                for (int k = 16 - pad; k < 16; k++) data[8*k +: 8] = 8'h00;
            end
            if (slot >= 0) begin
                exp_flits.push_back(data);
                exp_names.push_back($sformatf("datagram %0d data flit %0d", i, b));
            end
            idle_cycles(1);
        end
        beat_valid    = 1'b0;
        beat_last     = 1'b0;
        beat_padbytes = 4'd0;
    endtask

    // Outputs come from registers, so the falling edge sees them settled.
    always @(negedge clk) begin
        if (!rst && flit_valid) begin
            assert (next_check < exp_flits.size()) else begin
                $display("ERROR: flit %h arrived when no flit was expected", flit);
                abort_run();
            end
            assert (flit == exp_flits[next_check])
                else report_mismatch(exp_names[next_check], exp_flits[next_check], flit);
            next_check++;
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            $display("ERROR: timeout, the run did not finish within %0d cycles", cycle_limit);
            abort_run();
        end
    end

    initial begin
        int                    redirect_slot;
        logic [15:0]           port;
        udp_rx_pkg::port_entry e;
        rst           = 1'b1;
        hdr_valid     = 1'b0;
        src_ip        = '0;
        dst_ip        = '0;
        udp_hdr       = '0;
        stamp         = '0;
        beat_valid    = 1'b0;
        beat_data     = '0;
        beat_last     = 1'b0;
        beat_padbytes = '0;
        cfg_valid     = 1'b0;
        cfg_index     = '0;
        cfg_entry     = '0;
        draw_lengths();
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;
        // A narrow port range makes duplicate slots likely.
        for (int k = 0; k < table_entries; k++) begin
            port = 16'h1000 + 16'(rand_below(12));
            e    = random_entry(port, rand_below(8) != 0);
            write_slot(k, e);
        end
        redirect_slot = -1;
        for (int i = 0; i < n_dgrams; i++) begin
            if (redirect_slot >= 0) port = mirror[redirect_slot].port;
            else if (rand_below(4) == 0) port = 16'hf000 | 16'(rand_below(4096));
            else port = mirror[rand_below(table_entries)].port;
            send_datagram(i, port);
            if (i % 5 == 4) begin
                redirect_slot = rand_below(table_entries); // Next datagram follows the move.
                e = random_entry(mirror[redirect_slot].port, 1'b1);
                write_slot(redirect_slot, e);
                idle_cycles(gap_len[i] - 1);
            end
            else begin
                redirect_slot = -1;
                idle_cycles(gap_len[i]);
            end
            assert (drop_count == 16'(exp_drops))
                else report_mismatch($sformatf("datagram %0d drop count", i),
                                     128'(exp_drops), 128'(drop_count));
        end
        idle_cycles(4);
        if (next_check == exp_flits.size()) begin
            $display("PASS: all tests");
            $finish;
        end
        else begin
            $display("ERROR: %0d expected flits never appeared", exp_flits.size() - next_check);
            abort_run();
        end
    end

endmodule

// File: udp_rx_noc_out.f
source/udp_rx_pkg.sv
source/port_table.sv
source/udp_rx_noc_out_ctrl.sv
source/udp_rx_noc_out_datap.sv
source/udp_rx_noc_out.sv
tests/udp_rx_noc_out_tb.sv
